// ==== design/isa_pkg.sv ====
/*
  architectural constants and types for the fetch front end
  64-bit addresses, fixed 32-bit instructions, no compressed forms
*/
`default_nettype none

package isa_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 64;	// pc and branch target width
	localparam int INST_W = 32;	// one instruction word

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [INST_W-1:0] inst_t;

	////////////////////////////////////////////////////////////
	// program counter behaviour
	////////////////////////////////////////////////////////////

	// pc loaded on reset
	localparam addr_t RESET_PC = '0;

	// sequential step, one instruction
	// pc is always word aligned, bits 1:0 are never looked at
	localparam addr_t PC_STEP = ADDR_W'(4);

endpackage

`default_nettype wire

// ==== design/uarch_pkg.sv ====
/*
  micro-architecture geometry: instruction memory and fetch queue
  memory holds 256 lines of 64 bits, so pc wraps every 2 KiB
*/
`default_nettype none

package uarch_pkg;

	// instruction memory
	localparam int LINE_W       = 64;	// two instructions per line
	localparam int IMEM_LINES   = 256;
	localparam int LINE_IDX_W   = 8;	// log2 of IMEM_LINES
	localparam int LINE_LSB     = 3;	// pc bit where the line index starts
	localparam int WORD_SEL_BIT = 2;	// picks upper/lower word of a line

	typedef logic [LINE_W-1:0]     line_t;
	typedef logic [LINE_IDX_W-1:0] line_idx_t;

	// fetch queue, depth is a power of two
	localparam int FQ_DEPTH = 4;
	localparam int FQ_CNT_W = 3;	// holds 0..FQ_DEPTH

endpackage

`default_nettype wire

// ==== design/inst_mem.sv ====
/*
  line-wide instruction memory, one cycle read latency, no back-pressure
  the load port writes only while reset is high
  line contents are undefined until loaded
*/
`timescale 1ns/10ps
`default_nettype none

module inst_mem
	import uarch_pkg::*;
(
	input  logic      clock,
	input  logic      reset,

	// load port, used during reset only
	input  logic      load_en,
	input  line_idx_t load_idx,
	input  line_t     load_line,

	// read request from fetch
	input  logic      mem_req,
	input  line_idx_t mem_idx,

	// read response, one cycle after mem_req
	output logic      mem_resp_valid,
	output line_t     mem_resp_line
);

	line_t mem [IMEM_LINES];	// storage array

	////////////////////////////////////////////////////////////
	// storage and read data
	////////////////////////////////////////////////////////////

	// write side, loading outside reset is ignored
	always_ff @(posedge clock)
	begin
		if (load_en && reset)
			mem[load_idx] <= load_line;
	end

	// registered read, data only changes on a request
	always_ff @(posedge clock)
	begin
		if (mem_req)
			mem_resp_line <= mem[mem_idx];
	end

	////////////////////////////////////////////////////////////
	// response valid
	////////////////////////////////////////////////////////////

	// one-cycle pulse per request
	always_ff @(posedge clock)
	begin
		if (reset)
			mem_resp_valid <= 1'b0;
		else
			mem_resp_valid <= mem_req;	// exactly one cycle later
	end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
/*
  pc register and request logic with at most one memory read in flight
  requests go out only with a reserved queue slot, so enq is never refused
  taken branch overrides the stall and drops the response of that cycle
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
	import isa_pkg::*;
	import uarch_pkg::*;
(
	input  logic                clock,
	input  logic                reset,

	// redirect from later in the pipeline
	input  logic                branch_taken,
	input  addr_t               branch_target,

	// credit from the fetch queue
	input  logic [FQ_CNT_W-1:0] slots_free,

	// memory interface
	input  logic                mem_resp_valid,
	input  line_t               mem_resp_line,
	output logic                mem_req,
	output line_idx_t           mem_idx,

	// enqueue to the fetch queue
	output logic                enq_valid,
	output addr_t               enq_pc,
	output addr_t               enq_npc,
	output inst_t               enq_inst
);

	addr_t pc;			// pc being requested this cycle
	addr_t inflight_pc;	// pc of the request whose data returns next
	logic  inflight;	// one request outstanding
	logic  issue;
	logic  squash;		// response of this cycle belongs to the old path

	////////////////////////////////////////////////////////////
	// request side
	////////////////////////////////////////////////////////////

	// a free slot not already promised to the outstanding request
	// no issue in reset or on a branch since the pc is about to change
	assign issue = !reset && !branch_taken
	             && (slots_free > {{(FQ_CNT_W-1){1'b0}}, inflight});

	assign mem_req = issue;
	assign mem_idx = pc[LINE_LSB +: LINE_IDX_W];	// bits 10:3 wrap at 2 KiB

	// branch wins over the pc even while stalled
	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= RESET_PC;
		else if (branch_taken)
			pc <= branch_target;
		else if (issue)
			pc <= pc + PC_STEP;
	end

	// one bit of in-flight count covers the one-cycle latency
	always_ff @(posedge clock)
	begin
		if (reset)
			inflight <= 1'b0;
		else
			inflight <= issue;
	end

	// pc travels alongside the request
	always_ff @(posedge clock)
	begin
		if (issue)
			inflight_pc <= pc;
	end

	////////////////////////////////////////////////////////////
	// response side
	////////////////////////////////////////////////////////////

	assign squash    = branch_taken;	// fetched down the wrong path
	assign enq_valid = mem_resp_valid && !squash;
	assign enq_pc    = inflight_pc;
	assign enq_npc   = inflight_pc + PC_STEP;

	// pick the word out of the returned line
	assign enq_inst = inflight_pc[WORD_SEL_BIT] ? mem_resp_line[LINE_W-1 -: INST_W]
	                                            : mem_resp_line[INST_W-1:0];

endmodule

`default_nettype wire

// ==== design/fetch_queue.sv ====
/*
  small circular fetch queue, enqueue is never refused (credit upstream)
  flush empties it in the same edge and beats a concurrent enqueue
  outputs hold steady while valid is high and ready is low
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_queue
	import isa_pkg::*;
	import uarch_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                flush,		// taken branch

	// from fetch
	input  logic                enq_valid,
	input  addr_t               enq_pc,
	input  addr_t               enq_npc,
	input  inst_t               enq_inst,
	output logic [FQ_CNT_W-1:0] slots_free,

	// downstream, valid/ready
	input  logic                inst_ready,
	output logic                inst_valid,
	output inst_t               inst,
	output addr_t               inst_pc,
	output addr_t               inst_npc
);

	// entry storage, no reset needed
	addr_t pc_q   [FQ_DEPTH];
	addr_t npc_q  [FQ_DEPTH];
	inst_t inst_q [FQ_DEPTH];

	logic [$clog2(FQ_DEPTH)-1:0] head;	// oldest entry
	logic [$clog2(FQ_DEPTH)-1:0] tail;	// next free entry
	logic [FQ_CNT_W-1:0]         count;
	logic                        deq;

	assign deq        = inst_valid && inst_ready;
	assign inst_valid = (count != '0);
	assign slots_free = FQ_CNT_W'(FQ_DEPTH) - count;

	// head entry straight out
	assign inst     = inst_q[head];
	assign inst_pc  = pc_q[head];
	assign inst_npc = npc_q[head];

	////////////////////////////////////////////////////////////
	// pointers and count
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			if (enq_valid)
				tail <= tail + 1'b1;	// wraps, depth is a power of two
			if (deq)
				head <= head + 1'b1;
			case ({enq_valid, deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// payload write, a flushed write lands past the reset pointers
	always_ff @(posedge clock)
	begin
		if (enq_valid)
		begin
			pc_q[tail]   <= enq_pc;
			npc_q[tail]  <= enq_npc;
			inst_q[tail] <= enq_inst;
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
/*
  fetch front end top: memory, fetch stage and fetch queue
  load the memory while reset is high, fetch starts at RESET_PC
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
	import isa_pkg::*;
	import uarch_pkg::*;
(
	input  logic      clock,
	input  logic      reset,

	// program load
	input  logic      load_en,
	input  line_idx_t load_idx,
	input  line_t     load_line,

	// redirect
	input  logic      branch_taken,
	input  addr_t     branch_target,

	// instruction out
	input  logic      inst_ready,
	output logic      inst_valid,
	output inst_t     inst,
	output addr_t     inst_pc,
	output addr_t     inst_npc
);

	logic                mem_req;
	line_idx_t           mem_idx;
	logic                mem_resp_valid;
	line_t               mem_resp_line;
	logic                enq_valid;
	addr_t               enq_pc;
	addr_t               enq_npc;
	inst_t               enq_inst;
	logic [FQ_CNT_W-1:0] slots_free;

	inst_mem u_imem (
		.clock, .reset, .load_en, .load_idx, .load_line,
		.mem_req, .mem_idx, .mem_resp_valid, .mem_resp_line
	);

	fetch_stage u_fetch (
		.clock, .reset, .branch_taken, .branch_target, .slots_free,
		.mem_resp_valid, .mem_resp_line, .mem_req, .mem_idx,
		.enq_valid, .enq_pc, .enq_npc, .enq_inst
	);

	// a taken branch empties the queue
	fetch_queue u_fq (
		.clock, .reset, .flush(branch_taken),
		.enq_valid, .enq_pc, .enq_npc, .enq_inst, .slots_free,
		.inst_ready, .inst_valid, .inst, .inst_pc, .inst_npc
	);

endmodule

`default_nettype wire

// ==== verif/fetch_asserts.sv ====
/*
  protocol checks bound into every fetch_unit
  assumes a one-cycle memory and at most one request in flight
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_asserts
	import isa_pkg::*;
	import uarch_pkg::*;
(
	input logic                clock,
	input logic                reset,
	input logic                branch_taken,
	input logic                inst_valid,
	input logic                inst_ready,
	input inst_t               inst,
	input addr_t               inst_pc,
	input addr_t               inst_npc,
	input logic                mem_req,
	input logic                mem_resp_valid,
	input logic                enq_valid,
	input logic [FQ_CNT_W-1:0] slots_free
);

	int fails = 0;	// failed assertions so far

	// quiet during reset and the cycle after
	a_reset_quiet: assert property (@(posedge clock)
		reset |=> !inst_valid && !mem_resp_valid && !enq_valid)
	else
	begin
		$error("outputs active in or right after reset");
		fails++;
	end

	// stalled output holds unless a flush clears it
	a_hold: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !branch_taken |=>
			inst_valid && $stable(inst) && $stable(inst_pc) && $stable(inst_npc))
	else
	begin
		$error("output changed while stalled");
		fails++;
	end

	a_flush: assert property (@(posedge clock) disable iff (reset)
		branch_taken |=> !inst_valid)
	else
	begin
		$error("queue not empty after branch");
		fails++;
	end

	// request into an empty queue shows up two cycles later
	a_latency: assert property (@(posedge clock) disable iff (reset)
		mem_req && !inst_valid ##1 !branch_taken |=> inst_valid)
	else
	begin
		$error("instruction not delivered two cycles after its request");
		fails++;
	end

	a_credit: assert property (@(posedge clock) disable iff (reset)
		enq_valid |-> slots_free != '0)
	else
	begin
		$error("enqueue into a full queue");
		fails++;
	end

endmodule

bind fetch_unit fetch_asserts u_asserts (
	.clock(clock), .reset(reset), .branch_taken(branch_taken),
	.inst_valid(inst_valid), .inst_ready(inst_ready), .inst(inst),
	.inst_pc(inst_pc), .inst_npc(inst_npc), .mem_req(mem_req),
	.mem_resp_valid(mem_resp_valid), .enq_valid(enq_valid), .slots_free(slots_free)
);

`default_nettype wire

// ==== verif/fetch_tb.sv ====
/*
  testbench for fetch_unit, checks by concurrent assertions against a model pc
  reset stays high while the 256 lines load, then ten more cycles
  branch targets are always word aligned
*/
`timescale 1ns/10ps
`default_nettype none

module fetch_tb
	import isa_pkg::*;
	import uarch_pkg::*;
();

	// test lengths in cycles also size the watchdog
	localparam int RESET_CYCLES  = 10;
	localparam int STRAIGHT      = 200;
	localparam int RANDOM_READY  = 400;
	localparam int RANDOM_BRANCH = 400;
	localparam int STALL_ROUNDS  = 8;
	localparam int STALL_ROUND   = 35;	// 10 fill, 1 branch, 4 hold, 20 drain
	localparam int WRAP          = 60;
	localparam int TOTAL_CYCLES  = IMEM_LINES + RESET_CYCLES + STRAIGHT + RANDOM_READY
	                             + RANDOM_BRANCH + STALL_ROUNDS * STALL_ROUND + WRAP + 16;

	logic      clock;
	logic      reset;
	logic      load_en;
	line_idx_t load_idx;
	line_t     load_line;
	logic      branch_taken;
	addr_t     branch_target;
	logic      inst_ready;
	logic      inst_valid;
	inst_t     inst;
	addr_t     inst_pc;
	addr_t     inst_npc;

	line_t model_mem [IMEM_LINES];	// copy of what was loaded
	addr_t model_pc;				// pc of the next expected transfer
	logic  transfer;
	int    transfers      = 0;
	int    tb_fails       = 0;
	int    run_fails      = 0;
	int    tests_run      = 0;
	int    errors_mark    = 0;
	int    transfers_mark = 0;

	fetch_unit dut_i (.*);

	initial clock = 1'b0;
	always #4 clock = ~clock;	// 8 ns period

	assign transfer = inst_valid && inst_ready;

	////////////////////////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////////////////////////

	// line by pc bits 10:3 and upper half when bit 2 is set
	function automatic inst_t expected_inst(input addr_t pc);
		line_t line;
		line = model_mem[pc[10:3]];
		return pc[2] ? line[63:32] : line[31:0];
	endfunction

	always @(posedge clock)
	begin
		if (reset)
			model_pc <= RESET_PC;
		else if (branch_taken)
			model_pc <= branch_target;	// branch wins over a same-edge transfer
		else if (transfer)
			model_pc <= model_pc + 64'd4;
		if (!reset && transfer)
			transfers <= transfers + 1;
	end

	a_order: assert property (@(posedge clock) disable iff (reset)
		transfer |-> inst_pc == model_pc)
	else
	begin
		$error("FAIL %0t: inst_pc %h, expected %h", $time, inst_pc, model_pc);
		tb_fails++;
	end

	a_word: assert property (@(posedge clock) disable iff (reset)
		transfer |-> inst == expected_inst(model_pc))
	else
	begin
		$error("FAIL %0t: inst %h at pc %h, expected %h", $time, inst, model_pc,
			expected_inst(model_pc));
		tb_fails++;
	end

	a_npc: assert property (@(posedge clock) disable iff (reset)
		transfer |-> inst_npc == model_pc + 64'd4)
	else
	begin
		$error("FAIL %0t: inst_npc %h, expected %h", $time, inst_npc, model_pc + 64'd4);
		tb_fails++;
	end

	// bubble right after a redirect
	a_bubble: assert property (@(posedge clock) disable iff (reset)
		branch_taken |=> !inst_valid)
	else
	begin
		$error("FAIL %0t: inst_valid high the cycle after a branch", $time);
		tb_fails++;
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////

	function automatic int total_errors();
		return tb_fails + run_fails + dut_i.u_asserts.fails;
	endfunction

	task automatic load_program();
		line_t line;
		for (int i = 0; i < IMEM_LINES; i++)
		begin
			line = {$urandom, $urandom};
			model_mem[i] = line;
			load_en   <= 1'b1;
			load_idx  <= line_idx_t'(i);
			load_line <= line;
			@(posedge clock);
		end
		load_en <= 1'b0;
	endtask

	// aligned target and sometimes the upper word of the current line
	function automatic addr_t pick_target();
		if ($urandom % 4 == 0)
			return {model_pc[ADDR_W-1:3], 3'b100};
		return {$urandom, $urandom} & ~64'h3;
	endfunction

	task automatic run_cycles(input int n, input int ready_pct, input int branch_pct);
		repeat (n)
		begin
			inst_ready   <= ($urandom % 100) < ready_pct;
			branch_taken <= ($urandom % 100) < branch_pct;
			branch_target <= pick_target();
			@(posedge clock);
		end
		branch_taken <= 1'b0;
	endtask

	task automatic redirect(input addr_t target);
		branch_taken  <= 1'b1;
		branch_target <= target;
		@(posedge clock);
		branch_taken <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		int errs;
		int xfers;
		errs  = total_errors() - errors_mark;
		xfers = transfers - transfers_mark;
		if (xfers == 0)
		begin
			$display("%s: no instruction was delivered", name);
			run_fails++;
			errs++;
		end
		$display("test %-14s %s  transfers %0d  errors %0d", name,
			(errs == 0) ? "ok " : "bad", xfers, errs);
		errors_mark    = total_errors();
		transfers_mark = transfers;
		tests_run++;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(1));
		reset         = 1'b1;
		load_en       = 1'b0;
		load_idx      = '0;
		load_line     = '0;
		branch_taken  = 1'b0;
		branch_target = '0;
		inst_ready    = 1'b0;

		@(posedge clock);
		load_program();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		run_cycles(STRAIGHT, 100, 0);
		finish_test("straight");
		run_cycles(RANDOM_READY, 60, 0);
		finish_test("random_ready");
		run_cycles(RANDOM_BRANCH, 75, 6);
		finish_test("random_branch");

		// queue full and fetch stalled when the branch comes
		repeat (STALL_ROUNDS)
		begin
			inst_ready <= 1'b0;
			repeat (10) @(posedge clock);
			redirect(pick_target());
			repeat (4) @(posedge clock);
			inst_ready <= 1'b1;
			repeat (20) @(posedge clock);
		end
		finish_test("stall_branch");

		// from line 252 up across line 255 into line 0
		inst_ready <= 1'b1;
		redirect(64'h0000_0001_0000_07e4);
		repeat (WRAP) @(posedge clock);
		finish_test("wraparound");

		$display("tests %0d  transfers %0d  errors %0d", tests_run, transfers, total_errors());
		if (total_errors() == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// watchdog at four times the planned test length
	initial
	begin
		#(TOTAL_CYCLES * 4 * 8);
		$display("run timed out after %0d ns", TOTAL_CYCLES * 4 * 8);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
design/isa_pkg.sv
design/uarch_pkg.sv
design/inst_mem.sv
design/fetch_stage.sv
design/fetch_queue.sv
design/fetch_unit.sv
verif/fetch_asserts.sv
verif/fetch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := >>> PASS
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
